/* build.f */
+incdir+tb
rtl/drum_pkg.sv
rtl/row_ram.sv
rtl/node_update.sv
rtl/drum_column.sv
rtl/sweep_control.sv
rtl/audio_bus_master.sv
rtl/drum_synth_top.sv
tb/tb_drum_synth.sv

/* rtl/audio_bus_master.sv */
`default_nettype none

module audio_bus_master import drum_pkg::*; (
	input logic CLOCK_50,
	input logic rst,
	input sample_t sample,
	input logic sample_valid,
	output logic sample_taken,
	output bus_word_t bus_address,
	output logic bus_read,
	output logic bus_write,
	output bus_word_t bus_write_data,
	input logic bus_ack,
	input bus_word_t bus_read_data
);

	bus_state_t state;
	logic [7:0] fifo_space;
	bus_word_t sample_word;

	// Sign-extend to a full word, then align to the codec width
	assign sample_word = bus_word_t'(sample) << SAMPLE_SHIFT;

	// Pair done once the right channel is accepted
	assign sample_taken = (state == BS_WAIT_RIGHT) && bus_ack;

	//////////////////////////////
	// Bus FSM
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			state <= BS_READ_SPACE;
			bus_read <= 1'b0;
			bus_write <= 1'b0;
		end else begin
			case (state)
				BS_READ_SPACE: begin
					bus_address <= FIFO_SPACE_ADDR;
					bus_read <= 1'b1;
					state <= BS_WAIT_SPACE;
				end
				// Free words in the top byte
				BS_WAIT_SPACE: begin
					if (bus_ack) begin
						fifo_space <= bus_read_data[31:24];
						bus_read <= 1'b0;
						state <= BS_CHECK;
					end
				end
				BS_CHECK: begin
					if (fifo_space <= 8'(FIFO_MIN_SPACE)) begin
						state <= BS_READ_SPACE;
					end else if (sample_valid) begin
						state <= BS_WRITE_LEFT;
					end
				end
				BS_WRITE_LEFT: begin
					bus_address <= LEFT_ADDR;
					bus_write_data <= sample_word;
					bus_write <= 1'b1;
					state <= BS_WAIT_LEFT;
				end
				BS_WAIT_LEFT: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= BS_WRITE_RIGHT;
					end
				end
				// Same sample on both channels
				BS_WRITE_RIGHT: begin
					bus_address <= RIGHT_ADDR;
					bus_write_data <= sample_word;
					bus_write <= 1'b1;
					state <= BS_WAIT_RIGHT;
				end
				BS_WAIT_RIGHT: begin
					if (bus_ack) begin
						bus_write <= 1'b0;
						state <= BS_READ_SPACE;
					end
				end
				default: state <= BS_READ_SPACE;
			endcase
		end
	end

	one_request: assert property (@(posedge CLOCK_50) disable iff (rst)
		!(bus_read && bus_write));

endmodule

`default_nettype wire

/* rtl/drum_column.sv */
`default_nettype none

module drum_column import drum_pkg::*; #(
	parameter int COLS = 8,
	parameter int ROWS = 16,
	parameter int COL_INDEX = 0
) (
	input logic CLOCK_50,
	input logic rst,
	input sweep_phase_t phase,
	input row_t row,
	input row_t row_next,
	input sample_t rho,
	input sample_t incr,
	input sample_t left,
	input sample_t right,
	output sample_t node_out,
	output sample_t centre_value,
	output logic centre_strobe
);

	// Pyramid height factor of this column
	localparam int COL_MULT = (COL_INDEX + 1 < COLS - COL_INDEX) ? COL_INDEX + 1
		: COLS - COL_INDEX;
	localparam bit IS_CENTRE = (COL_INDEX == COLS / 2);

	sample_t col_step;
	sample_t load_acc;
	sample_t load_value;

	sample_t curr_q;
	sample_t prev_q;
	sample_t curr_reg;
	sample_t down_reg;
	sample_t up_in;
	sample_t down_in;
	sample_t next_value;

	logic ram_we;
	row_t curr_read_addr;
	sample_t curr_write_data;
	sample_t prev_write_data;

	//////////////////////////////
	// Pyramid loader
	//////////////////////////////

	assign col_step = sample_t'(incr * sample_t'(COL_MULT));

	// Rise to the middle row, flat across an even middle, then fall
	always_comb begin
		if (2 * int'(row) + 1 <= ROWS) begin
			load_value = load_acc + col_step;
		end else if (2 * int'(row) == ROWS) begin
			load_value = load_acc;
		end else begin
			load_value = load_acc - col_step;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (rst || phase == PH_CLEAR) begin
			load_acc <= '0;
		end else if (phase == PH_LOAD) begin
			load_acc <= load_value;
		end
	end

	//////////////////////////////
	// Row memories
	//////////////////////////////

	// Current grid is read one row further ahead for the up value
	assign curr_read_addr = (row_next == row_t'(ROWS - 1)) ? '0 : row_next + 1'b1;

	assign ram_we = (phase == PH_LOAD) || (phase == PH_SWEEP);
	assign curr_write_data = (phase == PH_LOAD) ? load_value : next_value;
	assign prev_write_data = (phase == PH_LOAD) ? load_value : curr_reg;

	row_ram u_curr_ram (
		.CLOCK_50   (CLOCK_50),
		.we         (ram_we),
		.write_addr (row),
		.write_data (curr_write_data),
		.read_addr  (curr_read_addr),
		.read_data  (curr_q)
	);

	row_ram u_prev_ram (
		.CLOCK_50   (CLOCK_50),
		.we         (ram_we),
		.write_addr (row),
		.write_data (prev_write_data),
		.read_addr  (row_next),
		.read_data  (prev_q)
	);

	//////////////////////////////
	// Node pipeline
	//////////////////////////////

	// Frozen while the grid waits in PH_HOLD
	always_ff @(posedge CLOCK_50) begin
		if (phase == PH_PRIME || phase == PH_SWEEP) begin
			curr_reg <= curr_q;
		end
		if (phase == PH_SWEEP) begin
			down_reg <= curr_reg;
		end
	end

	// Fixed edges at top and bottom
	assign up_in = (row == row_t'(ROWS - 1)) ? '0 : curr_q;
	assign down_in = (row == '0) ? '0 : down_reg;

	node_update u_node (
		.rho        (rho),
		.curr       (curr_reg),
		.prev       (prev_q),
		.left       (left),
		.right      (right),
		.up         (up_in),
		.down       (down_in),
		.next_value (next_value)
	);

	assign node_out = curr_reg;

	// Centre tap
	assign centre_value = next_value;
	assign centre_strobe = IS_CENTRE && (phase == PH_SWEEP) && (row == row_t'(ROWS / 2));

	row_in_range: assert property (@(posedge CLOCK_50) disable iff (rst)
		int'(row) < ROWS && int'(row_next) < ROWS);

endmodule

`default_nettype wire

/* rtl/drum_pkg.sv */
`default_nettype none

package drum_pkg;

	//////////////////////////////
	// Fixed-point and bus types
	//////////////////////////////

	// Node value, 1.17 two's complement
	typedef logic signed [17:0] sample_t;

	typedef logic [31:0] bus_word_t;

	typedef logic [9:0] row_t;

	//////////////////////////////
	// Audio core register map
	//////////////////////////////

	localparam bus_word_t FIFO_SPACE_ADDR = 32'h0000_3044;
	localparam bus_word_t LEFT_ADDR = 32'h0000_3048;
	localparam bus_word_t RIGHT_ADDR = 32'h0000_304C;

	// Pair is written only when reported space is above this
	localparam int unsigned FIFO_MIN_SPACE = 2;

	// Sample to bus word alignment
	localparam int unsigned SAMPLE_SHIFT = 14;

	//////////////////////////////
	// State encodings
	//////////////////////////////

	typedef enum logic [2:0] {
		PH_CLEAR,
		PH_LOAD,
		PH_PRIME,
		PH_SWEEP,
		PH_HOLD
	} sweep_phase_t;

	typedef enum logic [2:0] {
		BS_READ_SPACE,
		BS_WAIT_SPACE,
		BS_CHECK,
		BS_WRITE_LEFT,
		BS_WAIT_LEFT,
		BS_WRITE_RIGHT,
		BS_WAIT_RIGHT
	} bus_state_t;

endpackage

`default_nettype wire

/* rtl/drum_synth_top.sv */
`default_nettype none

module drum_synth_top import drum_pkg::*; #(
	parameter int COLS = 8,
	parameter int ROWS = 16
) (
	input logic CLOCK_50,
	input logic rst,
	input logic restart,
	input sample_t rho,
	input sample_t incr,
	output bus_word_t bus_address,
	output logic bus_read,
	output logic bus_write,
	output bus_word_t bus_write_data,
	input logic bus_ack,
	input bus_word_t bus_read_data
);

	sweep_phase_t phase;
	row_t row;
	row_t row_next;

	// Column values with a zero edge on each side
	sample_t row_values [COLS + 2];
	sample_t col_centre [COLS];
	logic col_strobe [COLS];

	sample_t sample;
	logic sample_valid;
	logic sample_taken;

	assign row_values[0] = '0;
	assign row_values[COLS + 1] = '0;

	sweep_control #(
		.ROWS (ROWS)
	) u_sweep (
		.CLOCK_50      (CLOCK_50),
		.rst           (rst),
		.restart       (restart),
		.centre_value  (col_centre[COLS / 2]),
		.centre_strobe (col_strobe[COLS / 2]),
		.sample_taken  (sample_taken),
		.phase         (phase),
		.row           (row),
		.row_next      (row_next),
		.sample        (sample),
		.sample_valid  (sample_valid)
	);

	//////////////////////////////
	// Grid columns
	//////////////////////////////

	for (genvar c = 0; c < COLS; c++) begin : g_col
		drum_column #(
			.COLS      (COLS),
			.ROWS      (ROWS),
			.COL_INDEX (c)
		) u_column (
			.CLOCK_50      (CLOCK_50),
			.rst           (rst),
			.phase         (phase),
			.row           (row),
			.row_next      (row_next),
			.rho           (rho),
			.incr          (incr),
			.left          (row_values[c]),
			.right         (row_values[c + 2]),
			.node_out      (row_values[c + 1]),
			.centre_value  (col_centre[c]),
			.centre_strobe (col_strobe[c])
		);
	end

	audio_bus_master u_bus (
		.CLOCK_50       (CLOCK_50),
		.rst            (rst),
		.sample         (sample),
		.sample_valid   (sample_valid),
		.sample_taken   (sample_taken),
		.bus_address    (bus_address),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_write_data (bus_write_data),
		.bus_ack        (bus_ack),
		.bus_read_data  (bus_read_data)
	);

endmodule

`default_nettype wire

/* rtl/node_update.sv */
`default_nettype none

module node_update import drum_pkg::*; (
	input sample_t rho,
	input sample_t curr,
	input sample_t prev,
	input sample_t left,
	input sample_t right,
	input sample_t up,
	input sample_t down,
	output sample_t next_value
);

	sample_t laplacian;
	logic signed [35:0] product;
	sample_t scaled;
	sample_t undamped;

	// Sum of neighbours minus four times the node
	assign laplacian = left + right + up + down - (curr <<< 2);

	// 1.17 multiply, sign bit kept above the integer bit
	assign product = laplacian * rho;
	assign scaled = {product[35], product[33:17]};

	// Leapfrog step with a small pull from the previous value
	assign undamped = scaled + (curr <<< 1) - prev + (prev >>> 10);

	// Damping
	assign next_value = undamped - (undamped >>> 9);

endmodule

`default_nettype wire

/* rtl/row_ram.sv */
`default_nettype none

module row_ram import drum_pkg::*; (
	input logic CLOCK_50,
	input logic we,
	input row_t write_addr,
	input sample_t write_data,
	input row_t read_addr,
	output sample_t read_data
);

	// One word per row index
	sample_t mem [2 ** $bits(row_t)];

	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			mem[write_addr] <= write_data;
		end
	end

	// Registered read, old word on a same-address write
	always_ff @(posedge CLOCK_50) begin
		read_data <= mem[read_addr];
	end

endmodule

`default_nettype wire

/* rtl/sweep_control.sv */
`default_nettype none

module sweep_control import drum_pkg::*; #(
	parameter int ROWS = 16
) (
	input logic CLOCK_50,
	input logic rst,
	input logic restart,
	input sample_t centre_value,
	input logic centre_strobe,
	input logic sample_taken,
	output sweep_phase_t phase,
	output row_t row,
	output row_t row_next,
	output sample_t sample,
	output logic sample_valid
);

	logic last_row;

	assign last_row = (row == row_t'(ROWS - 1));

	//////////////////////////////
	// Phase and row sequencing
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (rst || restart) begin
			phase <= PH_CLEAR;
			row <= '0;
		end else begin
			case (phase)
				PH_CLEAR: begin
					phase <= PH_LOAD;
					row <= '0;
				end
				PH_LOAD: begin
					if (last_row) begin
						phase <= PH_PRIME;
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end
				// Two cycles to fill the read pipeline
				PH_PRIME: begin
					if (row == row_t'(1)) begin
						phase <= sample_valid ? PH_HOLD : PH_SWEEP;
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end
				PH_SWEEP: begin
					if (last_row) begin
						phase <= sample_valid ? PH_HOLD : PH_SWEEP;
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end
				PH_HOLD: begin
					if (!sample_valid) begin
						phase <= PH_SWEEP;
					end
				end
				default: phase <= PH_CLEAR;
			endcase
		end
	end

	// Row read in this cycle for the next cycle's work
	always_comb begin
		case (phase)
			PH_PRIME: row_next = (row == '0) ? row_t'(ROWS - 1) : '0;
			PH_SWEEP: row_next = last_row ? '0 : row + 1'b1;
			default: row_next = '0;
		endcase
	end

	//////////////////////////////
	// Sample hold
	//////////////////////////////

	always_ff @(posedge CLOCK_50) begin
		if (rst) begin
			sample_valid <= 1'b0;
		end else if (centre_strobe) begin
			sample_valid <= 1'b1;
		end else if (sample_taken) begin
			sample_valid <= 1'b0;
		end
	end

	always_ff @(posedge CLOCK_50) begin
		if (centre_strobe) begin
			sample <= centre_value;
		end
	end

	// The sweep must hold before a new centre overwrites a waiting one
	no_overwrite: assert property (@(posedge CLOCK_50) disable iff (rst)
		centre_strobe |-> !sample_valid);

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile the drum synth and its testbench with Verilator, then run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert \
	--top-module tb_drum_synth \
	-f build.f

# A failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/Vtb_drum_synth

/* tb/drum_model.svh */
`ifndef DRUM_MODEL_SVH
`define DRUM_MODEL_SVH

//////////////////////////////
// Reference drum grid
//////////////////////////////

// Indexed [column][row]
sample_t grid_curr [COLS][ROWS];
sample_t grid_prev [COLS][ROWS];

// Height of the pyramid along one axis, counted from the nearer edge
function automatic int pyramid_factor(input int pos, input int size);
	int from_far_edge;
	from_far_edge = size - pos;
	return (pos + 1 < from_far_edge) ? pos + 1 : from_far_edge;
endfunction

// Pyramid start, grid at rest so previous equals current
function automatic void seed_grid(input sample_t height);
	for (int c = 0; c < COLS; c++) begin
		for (int r = 0; r < ROWS; r++) begin
			grid_curr[c][r] = sample_t'(int'(height) * pyramid_factor(c, COLS)
				* pyramid_factor(r, ROWS));
			grid_prev[c][r] = grid_curr[c][r];
		end
	end
endfunction

function automatic sample_t node_next(input sample_t tension, input sample_t curr,
		input sample_t prev, input sample_t left, input sample_t right,
		input sample_t up, input sample_t down);
	sample_t lap;
	longint prod;
	sample_t scaled;
	sample_t sum;
	lap = sample_t'(int'(left) + int'(right) + int'(up) + int'(down) - 4 * int'(curr));
	prod = longint'(lap) * longint'(tension);
	// Sign bit, then 17 fraction bits below the integer bit
	scaled = {prod[35], prod[33:17]};
	sum = sample_t'(int'(scaled) + 2 * int'(curr) - int'(prev) + (int'(prev) >>> 10));
	return sample_t'(int'(sum) - (int'(sum) >>> 9));
endfunction

// All nodes advance together, with zero beyond every edge
function automatic void step_grid(input sample_t tension);
	sample_t next_grid [COLS][ROWS];
	sample_t left;
	sample_t right;
	sample_t up;
	sample_t down;
	for (int c = 0; c < COLS; c++) begin
		for (int r = 0; r < ROWS; r++) begin
			left = (c == 0) ? sample_t'(0) : grid_curr[c - 1][r];
			right = (c == COLS - 1) ? sample_t'(0) : grid_curr[c + 1][r];
			down = (r == 0) ? sample_t'(0) : grid_curr[c][r - 1];
			up = (r == ROWS - 1) ? sample_t'(0) : grid_curr[c][r + 1];
			next_grid[c][r] = node_next(tension, grid_curr[c][r], grid_prev[c][r],
				left, right, up, down);
		end
	end
	grid_prev = grid_curr;
	grid_curr = next_grid;
endfunction

function automatic sample_t centre_node();
	return grid_curr[COLS / 2][ROWS / 2];
endfunction

`endif

/* tb/tb_drum_synth.sv */
`default_nettype none

module tb_drum_synth import drum_pkg::*; ();

	localparam int COLS = 8;
	localparam int ROWS = 16;
	localparam int REQ_TIMEOUT = 1000;
	localparam int POLL_LIMIT = 40;
	localparam int NUM_SAMPLES = 40;

	logic CLOCK_50 = 1'b0;
	logic rst;
	logic restart;
	sample_t rho;
	sample_t incr;
	bus_word_t bus_address;
	logic bus_read;
	logic bus_write;
	bus_word_t bus_write_data;
	logic bus_ack;
	bus_word_t bus_read_data;

	// Tension the reference model steps with
	sample_t model_rho;
	int low_polls;

	`include "drum_model.svh"

	drum_synth_top #(
		.COLS (COLS),
		.ROWS (ROWS)
	) dut (
		.CLOCK_50       (CLOCK_50),
		.rst            (rst),
		.restart        (restart),
		.rho            (rho),
		.incr           (incr),
		.bus_address    (bus_address),
		.bus_read       (bus_read),
		.bus_write      (bus_write),
		.bus_write_data (bus_write_data),
		.bus_ack        (bus_ack),
		.bus_read_data  (bus_read_data)
	);

	always #20 CLOCK_50 = ~CLOCK_50;

	//////////////////////////////
	// Checks
	//////////////////////////////

	task automatic stop_on_error();
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input bus_word_t got, input bus_word_t want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, want);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic want);
		if (got !== want) begin
			$display("MISMATCH %s: got 0x%h expected 0x%h", name, got, want);
			stop_on_error();
		end
	endtask

	// Sign-extended to a word, then aligned to the codec width
	function automatic bus_word_t word_of_sample(input sample_t value);
		int wide;
		wide = int'(value);
		return bus_word_t'(wide << SAMPLE_SHIFT);
	endfunction

	//////////////////////////////
	// Audio core responder
	//////////////////////////////

	task automatic serve_access(output logic is_write, output bus_word_t addr,
			output bus_word_t data, output logic [7:0] space);
		int waited;
		int delay;
		waited = 0;
		space = 8'($urandom_range(8));
		while (!bus_read && !bus_write && waited < REQ_TIMEOUT) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (!bus_read && !bus_write) begin
			$display("No bus request arrived within %0d cycles", REQ_TIMEOUT);
			stop_on_error();
		end
		check_bit("bus_read & bus_write", bus_read & bus_write, 1'b0);
		is_write = bus_write;
		addr = bus_address;
		data = bus_write_data;
		delay = int'($urandom_range(5));
		// Request has to stay put until it is acknowledged
		for (int i = 0; i < delay; i++) begin
			@(negedge CLOCK_50);
			check_bit("bus_read", bus_read, !is_write);
			check_bit("bus_write", bus_write, is_write);
			check_word("bus_address", bus_address, addr);
			if (is_write) begin
				check_word("bus_write_data", bus_write_data, data);
			end
		end
		bus_read_data = {space, 24'($urandom)};
		bus_ack = 1'b1;
		@(negedge CLOCK_50);
		bus_ack = 1'b0;
		check_bit("bus_read", bus_read, 1'b0);
		check_bit("bus_write", bus_write, 1'b0);
	endtask

	task automatic expect_space_read(output logic [7:0] space);
		logic is_write;
		bus_word_t addr;
		bus_word_t data;
		serve_access(is_write, addr, data, space);
		check_bit("bus_write", is_write, 1'b0);
		check_word("bus_address", addr, FIFO_SPACE_ADDR);
		if (space <= FIFO_MIN_SPACE) begin
			low_polls++;
		end
	endtask

	task automatic expect_write(input bus_word_t want_addr, output bus_word_t data);
		logic is_write;
		bus_word_t addr;
		logic [7:0] space;
		serve_access(is_write, addr, data, space);
		check_bit("bus_write", is_write, 1'b1);
		check_word("bus_address", addr, want_addr);
	endtask

	//////////////////////////////
	// Scoreboard
	//////////////////////////////

	// Low space sends the loop back to another read with no write
	task automatic play_pairs(input int count);
		logic [7:0] space;
		int done;
		int polls;
		sample_t want;
		bus_word_t left_data;
		bus_word_t right_data;
		done = 0;
		polls = 0;
		while (done < count && polls < count * POLL_LIMIT) begin
			expect_space_read(space);
			polls++;
			if (space > FIFO_MIN_SPACE) begin
				step_grid(model_rho);
				want = centre_node();
				expect_write(LEFT_ADDR, left_data);
				check_sample("sample (left)", sample_t'(left_data >> SAMPLE_SHIFT), want);
				check_word("bus_write_data (left)", left_data, word_of_sample(want));
				expect_write(RIGHT_ADDR, right_data);
				check_word("bus_write_data (right)", right_data, word_of_sample(want));
				done++;
			end
		end
		if (done < count) begin
			$display("Only %0d of %0d sample pairs were written", done, count);
			stop_on_error();
		end
	endtask

	// Restart lands between the left and right writes of one pair
	task automatic restart_mid_pair();
		logic [7:0] space;
		int polls;
		bus_word_t left_data;
		bus_word_t right_data;
		space = '0;
		polls = 0;
		while (space <= FIFO_MIN_SPACE && polls < POLL_LIMIT) begin
			expect_space_read(space);
			polls++;
		end
		if (space <= FIFO_MIN_SPACE) begin
			$display("FIFO space never rose above the minimum before the restart");
			stop_on_error();
		end
		step_grid(model_rho);
		expect_write(LEFT_ADDR, left_data);
		check_word("bus_write_data (left)", left_data, word_of_sample(centre_node()));
		model_rho = sample_t'($urandom_range(32'h4000));
		rho = model_rho;
		incr = sample_t'($urandom_range(32'h1ff));
		restart = 1'b1;
		@(negedge CLOCK_50);
		restart = 1'b0;
		// Old pair finishes but is no part of the new sequence
		expect_write(RIGHT_ADDR, right_data);
		check_word("bus_write_data (right)", right_data, word_of_sample(centre_node()));
		seed_grid(incr);
	endtask

	initial begin
		void'($urandom(32'h0a38_ca48));
		rst = 1'b1;
		restart = 1'b0;
		bus_ack = 1'b0;
		bus_read_data = '0;
		low_polls = 0;
		model_rho = sample_t'($urandom_range(32'h4000));
		rho = model_rho;
		incr = sample_t'($urandom_range(32'h1ff));
		repeat (16) @(negedge CLOCK_50);
		check_bit("bus_read", bus_read, 1'b0);
		check_bit("bus_write", bus_write, 1'b0);
		rst = 1'b0;
		seed_grid(incr);
		play_pairs(NUM_SAMPLES);
		restart_mid_pair();
		play_pairs(NUM_SAMPLES);
		if (low_polls == 0) begin
			$display("No FIFO space read at or below the minimum was exercised");
			stop_on_error();
		end else begin
			$display("TESTBENCH PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
